//--- build.f
verilog/gmii_tx_pkg.sv
verilog/crc32_8023.sv
verilog/tx_queue_select.sv
verilog/tx_frame_sequencer.sv
verilog/tx_mgnt_report.sv
verilog/mac_tx_gmii.sv
sim/mac_tx_gmii_chk.sv
sim/tb_mac_tx_gmii.sv

//--- sim/tb_mac_tx_gmii.sv
`timescale 1ns/1ps

module tb_mac_tx_gmii;
    import gmii_tx_pkg::*;

    // frame count over all tests and the longest payload
    localparam int NUM_FRAMES = 29;
    localparam int MAX_LEN    = 64;
    localparam int SEED       = 20;

    logic         interface_clk;
    logic         rstn_mac        = 1'b0;
    logic         gtx_dv;
    byte_t        gtx_d;
    logic         data_fifo_rd;
    logic         tdata_fifo_rd;
    logic         ptr_fifo_rd;
    logic         tptr_fifo_rd;
    byte_t        data_fifo_din   = '0;
    byte_t        tdata_fifo_din  = '0;
    ptr_word_t    ptr_fifo_din    = '0;
    ptr_word_t    tptr_fifo_din   = '0;
    logic         ptr_fifo_empty  = 1'b1;
    logic         tptr_fifo_empty = 1'b1;
    logic         tx_mgnt_resp    = 1'b0;
    logic         tx_mgnt_valid;
    mgnt_report_t tx_mgnt_data;

    // fifo contents and the strobes seen at the last rising edge
    byte_t        data_q[$];
    byte_t        tdata_q[$];
    ptr_word_t    ptr_q[$];
    ptr_word_t    tptr_q[$];
    logic         data_rd_seen  = 1'b0;
    logic         tdata_rd_seen = 1'b0;
    logic         ptr_rd_seen   = 1'b0;
    logic         tptr_rd_seen  = 1'b0;

    // expected wire bytes and reports in send order
    byte_t        exp_bytes[$];
    frame_len_t   exp_lens[$];
    mgnt_report_t exp_reports[$];
    frame_len_t   lens[NUM_FRAMES];
    mgnt_report_t held_rep;
    string        test_name      = "startup";
    int           len_idx        = 0;
    int           frames_pending = 0;
    int           frames_seen    = 0;
    int           cycle_cnt      = 0;
    int           cycle_limit    = 0;
    logic         resp_auto      = 1'b1;
    int           resp_wait      = 0;
    int           report_cnt     = 0;
    logic         in_frame       = 1'b0;
    int           wire_cnt       = 0;
    int           gap_cnt        = 0;

    mac_tx_gmii u_dut (.*);

    initial begin
        interface_clk = 1'b0;
        forever #4 interface_clk = ~interface_clk;
    end

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    // reflected crc with each byte xored into the low end
    function automatic crc_t ref_crc(input byte_t data[$]);
        crc_t c;
        c = '1;
        for (int n = 0; n < data.size(); n++) begin
            c = c ^ {24'h0, data[n]};
            for (int k = 0; k < 8; k++) begin
                c = c[0] ? ((c >> 1) ^ 32'hedb8_8320) : (c >> 1);
            end
        end
        return c;
    endfunction

    // preamble and sfd ahead of the payload and a low-byte-first fcs
    function automatic void build_frame(input byte_t payload[$], output byte_t frame[$]);
        crc_t fcs;
        frame = {};
        for (int i = 0; i < 7; i++) begin
            frame.push_back(8'h55);
        end
        frame.push_back(8'hd5);
        for (int i = 0; i < payload.size(); i++) begin
            frame.push_back(payload[i]);
        end
        fcs = ~ref_crc(payload);
        for (int i = 0; i < 4; i++) begin
            frame.push_back(fcs[8*i +: 8]);
        end
    endfunction

    ////////////////////////////////////////////////////////////
    // compare and stop
    ////////////////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_byte(input string name, input byte_t exp, input byte_t act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] %s expected %02h actual %02h", name, exp, act));
        end
    endtask

    task automatic check_len(input string name, input frame_len_t exp, input frame_len_t act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic check_report(input string name, input mgnt_report_t exp,
                                input mgnt_report_t act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] %s expected %04h actual %04h", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] %s expected %b actual %b", name, exp, act));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // fifo models
    ////////////////////////////////////////////////////////////

    always @(posedge interface_clk) begin
        data_rd_seen  <= data_fifo_rd;
        tdata_rd_seen <= tdata_fifo_rd;
        ptr_rd_seen   <= ptr_fifo_rd;
        tptr_rd_seen  <= tptr_fifo_rd;
    end

    // word lands on din the cycle after its strobe
    always @(negedge interface_clk) begin
        if (data_rd_seen) begin
            if (data_q.size() == 0) abort_run("best-effort data FIFO read while empty");
            data_fifo_din <= data_q.pop_front();
        end
        if (tdata_rd_seen) begin
            if (tdata_q.size() == 0) abort_run("TTE data FIFO read while empty");
            tdata_fifo_din <= tdata_q.pop_front();
        end
        if (ptr_rd_seen) begin
            if (ptr_q.size() == 0) abort_run("best-effort pointer FIFO read while empty");
            ptr_fifo_din <= ptr_q.pop_front();
        end
        if (tptr_rd_seen) begin
            if (tptr_q.size() == 0) abort_run("TTE pointer FIFO read while empty");
            tptr_fifo_din <= tptr_q.pop_front();
        end
        ptr_fifo_empty  <= (ptr_q.size() == 0);
        tptr_fifo_empty <= (tptr_q.size() == 0);
    end

    ////////////////////////////////////////////////////////////
    // gmii monitor, management responder, timeout
    ////////////////////////////////////////////////////////////

    always @(negedge interface_clk) begin
        if (rstn_mac && gtx_dv) begin
            if (!in_frame) begin
                if (frames_seen > 0 && gap_cnt < IFG_LEN) begin
                    abort_run($sformatf(
                        "[FAIL] %s gap before frame %0d expected >= %0d actual %0d",
                        test_name, frames_seen, IFG_LEN, gap_cnt));
                end
                in_frame = 1'b1;
                wire_cnt = 0;
            end
            if (exp_bytes.size() == 0) abort_run("GMII byte sent with no frame expected");
            check_byte($sformatf("%s frame %0d byte %0d", test_name, frames_seen, wire_cnt),
                       exp_bytes.pop_front(), gtx_d);
            wire_cnt++;
        end else if (rstn_mac) begin
            if (in_frame) begin
                // payload length from wire count minus framing overhead
                check_len($sformatf("%s frame %0d length", test_name, frames_seen),
                          exp_lens.pop_front(), frame_len_t'(wire_cnt - 12));
                in_frame = 1'b0;
                gap_cnt  = 0;
                frames_seen++;
                frames_pending--;
            end
            gap_cnt++;
        end
    end

    // one-cycle resp after a short varying delay
    always @(negedge interface_clk) begin
        if (tx_mgnt_resp) begin
            tx_mgnt_resp <= 1'b0;
        end else if (resp_auto && tx_mgnt_valid) begin
            if (resp_wait == 0) begin
                if (exp_reports.size() == 0) begin
                    abort_run("management report with no frame behind it");
                end
                check_report($sformatf("%s report %0d", test_name, report_cnt),
                             exp_reports.pop_front(), tx_mgnt_data);
                tx_mgnt_resp <= 1'b1;
                report_cnt++;
                resp_wait = report_cnt % 3;
            end else begin
                resp_wait--;
            end
        end
    end

    always @(posedge interface_clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) abort_run("timeout, frames did not finish in time");
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    // payload before its pointer with noise in the upper pointer bits
    task automatic push_frame(input logic tte, output mgnt_report_t rep);
        frame_len_t len;
        byte_t      payload[$];
        byte_t      frame[$];
        ptr_word_t  ptr;
        len = lens[len_idx];
        len_idx++;
        for (int i = 0; i < len; i++) begin
            payload.push_back(byte_t'($urandom));
        end
        build_frame(payload, frame);
        for (int i = 0; i < len; i++) begin
            if (tte) tdata_q.push_back(payload[i]);
            else data_q.push_back(payload[i]);
        end
        ptr = {4'($urandom), len};
        if (tte) tptr_q.push_back(ptr);
        else ptr_q.push_back(ptr);
        for (int i = 0; i < frame.size(); i++) begin
            exp_bytes.push_back(frame[i]);
        end
        exp_lens.push_back(len);
        rep.flags = {tte, 3'b000};
        rep.len   = len;
        frames_pending++;
    endtask

    // tte frames queued ahead of normal ones so the wire order matches
    task automatic send_batch(input int n_tte, input int n_norm);
        mgnt_report_t rep;
        @(posedge interface_clk);
        for (int n = 0; n < n_tte + n_norm; n++) begin
            push_frame(n < n_tte, rep);
            if (n == 0) held_rep = rep;
            // held slot takes only the first frame
            if (resp_auto || n == 0) exp_reports.push_back(rep);
        end
    endtask

    task automatic wait_frames_done();
        while (frames_pending != 0) @(negedge interface_clk);
    endtask

    initial begin
        int unsigned seed_ret;
        int          n_tte;
        seed_ret = $urandom(SEED);
        for (int i = 0; i < NUM_FRAMES; i++) begin
            lens[i]     = frame_len_t'(1 + $urandom % MAX_LEN);
            cycle_limit += lens[i] + 12 + IFG_LEN + 10;
        end
        cycle_limit += 200;
        repeat (2) @(posedge interface_clk);
        @(negedge interface_clk);
        rstn_mac <= 1'b1;

        // quiet outputs with no pointer queued
        test_name = "reset_idle";
        repeat (10) begin
            @(negedge interface_clk);
            check_bit("reset_idle gtx_dv", 1'b0, gtx_dv);
            check_byte("reset_idle gtx_d", 8'h00, gtx_d);
            check_bit("reset_idle data_fifo_rd", 1'b0, data_fifo_rd);
            check_bit("reset_idle tdata_fifo_rd", 1'b0, tdata_fifo_rd);
            check_bit("reset_idle ptr_fifo_rd", 1'b0, ptr_fifo_rd);
            check_bit("reset_idle tptr_fifo_rd", 1'b0, tptr_fifo_rd);
            check_bit("reset_idle tx_mgnt_valid", 1'b0, tx_mgnt_valid);
        end

        test_name = "single_frame";
        send_batch(0, 1);
        wait_frames_done();

        // both queues waiting and then a tte frame behind a running normal one
        test_name = "priority";
        send_batch(1, 1);
        wait_frames_done();
        send_batch(0, 1);
        while (!gtx_dv) @(negedge interface_clk);
        send_batch(1, 1);
        wait_frames_done();

        test_name = "back_to_back";
        n_tte = 5 + $urandom % 11;
        send_batch(n_tte, 20 - n_tte);
        wait_frames_done();

        // resp held low over three frames
        test_name = "held_report";
        @(posedge interface_clk);
        resp_auto = 1'b0;
        send_batch(1, 2);
        while (!tx_mgnt_valid) @(negedge interface_clk);
        while (frames_pending != 0) begin
            check_bit("held_report valid", 1'b1, tx_mgnt_valid);
            check_report("held_report data", held_rep, tx_mgnt_data);
            @(negedge interface_clk);
        end
        @(posedge interface_clk);
        resp_auto = 1'b1;
        while (!tx_mgnt_resp) @(posedge interface_clk);
        @(negedge interface_clk);
        check_bit("held_report valid after resp", 1'b0, tx_mgnt_valid);

        repeat (IFG_LEN + 4) @(negedge interface_clk);
        if (exp_bytes.size() != 0 || exp_reports.size() != 0) begin
            abort_run("frames or reports still outstanding at end of run");
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

//--- sim/mac_tx_gmii_chk.sv
`timescale 1ns/1ps

module mac_tx_gmii_chk (
    input logic                      interface_clk,
    input logic                      rstn_mac,
    input logic                      data_fifo_rd,
    input logic                      tdata_fifo_rd,
    input logic                      ptr_fifo_rd,
    input logic                      tptr_fifo_rd,
    input logic                      tx_mgnt_valid,
    input logic                      tx_mgnt_resp,
    input gmii_tx_pkg::mgnt_report_t tx_mgnt_data
);

    ////////////////////////////////////////////////////////////
    // read strobes
    ////////////////////////////////////////////////////////////

    // one payload fifo per frame
    a_one_data_fifo: assert property (@(posedge interface_clk) disable iff (!rstn_mac)
        !(data_fifo_rd && tdata_fifo_rd))
        else $error("both data FIFOs read in one cycle");

    // pointer strobes are single cycle
    a_ptr_pulse: assert property (@(posedge interface_clk) disable iff (!rstn_mac)
        ptr_fifo_rd |=> !ptr_fifo_rd)
        else $error("best-effort pointer read longer than one cycle");

    a_tptr_pulse: assert property (@(posedge interface_clk) disable iff (!rstn_mac)
        tptr_fifo_rd |=> !tptr_fifo_rd)
        else $error("TTE pointer read longer than one cycle");

    ////////////////////////////////////////////////////////////
    // management report
    ////////////////////////////////////////////////////////////

    // pending report frozen until resp
    a_report_hold: assert property (@(posedge interface_clk) disable iff (!rstn_mac)
        (tx_mgnt_valid && !tx_mgnt_resp) |=> $stable(tx_mgnt_data))
        else $error("report data changed while pending");

endmodule

bind mac_tx_gmii mac_tx_gmii_chk u_chk (.*);

//--- verilog/mac_tx_gmii.sv
`timescale 1ns/1ps

module mac_tx_gmii (
    input  logic                      interface_clk,
    input  logic                      rstn_mac,
    // gmii transmit
    output logic                      gtx_dv,
    output gmii_tx_pkg::byte_t        gtx_d,
    // best effort queue
    output logic                      data_fifo_rd,
    input  gmii_tx_pkg::byte_t        data_fifo_din,
    output logic                      ptr_fifo_rd,
    input  gmii_tx_pkg::ptr_word_t    ptr_fifo_din,
    input  logic                      ptr_fifo_empty,
    // tte queue
    output logic                      tdata_fifo_rd,
    input  gmii_tx_pkg::byte_t        tdata_fifo_din,
    output logic                      tptr_fifo_rd,
    input  gmii_tx_pkg::ptr_word_t    tptr_fifo_din,
    input  logic                      tptr_fifo_empty,
    // management side
    output logic                      tx_mgnt_valid,
    output gmii_tx_pkg::mgnt_report_t tx_mgnt_data,
    input  logic                      tx_mgnt_resp
);
    import gmii_tx_pkg::*;

    logic        frame_start;
    logic        frame_done;
    frame_desc_t frame_desc;

    ////////////////////////////////////////////////////////////
    // frame path
    ////////////////////////////////////////////////////////////

    // picks a queue and fetches its pointer
    tx_queue_select u_queue_select (
        .interface_clk   (interface_clk),
        .rstn_mac        (rstn_mac),
        .ptr_fifo_empty  (ptr_fifo_empty),
        .tptr_fifo_empty (tptr_fifo_empty),
        .ptr_fifo_din    (ptr_fifo_din),
        .tptr_fifo_din   (tptr_fifo_din),
        .frame_done      (frame_done),
        .ptr_fifo_rd     (ptr_fifo_rd),
        .tptr_fifo_rd    (tptr_fifo_rd),
        .frame_start     (frame_start),
        .frame_desc      (frame_desc)
    );

    // preamble, payload, fcs, gap
    tx_frame_sequencer u_sequencer (
        .interface_clk  (interface_clk),
        .rstn_mac       (rstn_mac),
        .frame_start    (frame_start),
        .frame_desc     (frame_desc),
        .data_fifo_din  (data_fifo_din),
        .tdata_fifo_din (tdata_fifo_din),
        .data_fifo_rd   (data_fifo_rd),
        .tdata_fifo_rd  (tdata_fifo_rd),
        .gtx_dv         (gtx_dv),
        .gtx_d          (gtx_d),
        .frame_done     (frame_done)
    );

    ////////////////////////////////////////////////////////////
    // management report, watches frame starts
    ////////////////////////////////////////////////////////////

    tx_mgnt_report u_mgnt_report (
        .interface_clk (interface_clk),
        .rstn_mac      (rstn_mac),
        .frame_start   (frame_start),
        .frame_desc    (frame_desc),
        .tx_mgnt_resp  (tx_mgnt_resp),
        .tx_mgnt_valid (tx_mgnt_valid),
        .tx_mgnt_data  (tx_mgnt_data)
    );

endmodule

//--- verilog/tx_mgnt_report.sv
`timescale 1ns/1ps

module tx_mgnt_report (
    input  logic                      interface_clk,
    input  logic                      rstn_mac,
    input  logic                      frame_start,
    input  gmii_tx_pkg::frame_desc_t  frame_desc,
    input  logic                      tx_mgnt_resp,
    output logic                      tx_mgnt_valid,
    output gmii_tx_pkg::mgnt_report_t tx_mgnt_data
);
    import gmii_tx_pkg::*;

    mgnt_report_t report_next;
    // new report only when the slot is free
    logic         report_load;

    assign report_next.flags = {frame_desc.tte, 3'b000};
    assign report_next.len   = frame_desc.len;
    assign report_load       = frame_start && !tx_mgnt_valid;

    // pending flag, dropped once resp is seen
    always_ff @(posedge interface_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            tx_mgnt_valid <= 1'b0;
        end else if (report_load) begin
            tx_mgnt_valid <= 1'b1;
        end else if (tx_mgnt_valid && tx_mgnt_resp) begin
            tx_mgnt_valid <= 1'b0;
        end
    end

    // report word, frozen while pending
    always_ff @(posedge interface_clk) begin
        if (report_load) begin
            tx_mgnt_data <= report_next;
        end
    end

endmodule

//--- verilog/tx_frame_sequencer.sv
`timescale 1ns/1ps

module tx_frame_sequencer (
    input  logic                     interface_clk,
    input  logic                     rstn_mac,
    input  logic                     frame_start,
    input  gmii_tx_pkg::frame_desc_t frame_desc,
    input  gmii_tx_pkg::byte_t       data_fifo_din,
    input  gmii_tx_pkg::byte_t       tdata_fifo_din,
    output logic                     data_fifo_rd,
    output logic                     tdata_fifo_rd,
    output logic                     gtx_dv,
    output gmii_tx_pkg::byte_t       gtx_d,
    output logic                     frame_done
);
    import gmii_tx_pkg::*;

    // state names the byte being loaded into gtx_d this cycle
    seq_state_t state;
    frame_len_t byte_cnt;
    frame_len_t last_data;
    byte_t      din_sel;
    byte_t      fcs_byte;
    logic       rd_en;
    logic       crc_init;
    logic       crc_calc;
    logic       crc_shift;

    ////////////////////////////////////////////////////////////
    // data fifo read and byte select
    ////////////////////////////////////////////////////////////

    assign din_sel   = frame_desc.tte ? tdata_fifo_din : data_fifo_din;
    assign last_data = frame_desc.len - 1'b1;

    // read one cycle ahead of each data load
    // first strobe while sfd is loaded, last one before the final byte
    assign rd_en = (state == seq_sfd) ||
                   ((state == seq_data) && (byte_cnt != last_data));

    assign data_fifo_rd  = rd_en && !frame_desc.tte;
    assign tdata_fifo_rd = rd_en && frame_desc.tte;

    // handshake back to the arbiter on the last gap cycle
    assign frame_done = (state == seq_gap) &&
                        (byte_cnt == frame_len_t'(IFG_LEN - 1));

    // crc restarts with the frame, accumulates payload only
    assign crc_init  = (state == seq_idle) && frame_start;
    assign crc_calc  = (state == seq_data);
    assign crc_shift = (state == seq_fcs);

    ////////////////////////////////////////////////////////////
    // framing fsm and output registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge interface_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            state    <= seq_idle;
            byte_cnt <= '0;
            gtx_d    <= '0;
            gtx_dv   <= 1'b0;
        end else begin
            case (state)
                seq_idle: begin
                    gtx_d  <= '0;
                    gtx_dv <= 1'b0;
                    // first preamble byte goes out straight from idle
                    if (frame_start) begin
                        state    <= seq_preamble;
                        byte_cnt <= frame_len_t'(1);
                        gtx_d    <= PREAMBLE_BYTE;
                        gtx_dv   <= 1'b1;
                    end
                end
                seq_preamble: begin
                    gtx_d <= PREAMBLE_BYTE;
                    if (byte_cnt == frame_len_t'(PREAMBLE_LEN - 1)) begin
                        state <= seq_sfd;
                    end else begin
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                end
                seq_sfd: begin
                    gtx_d    <= SFD_BYTE;
                    byte_cnt <= '0;
                    state    <= seq_data;
                end
                seq_data: begin
                    // din holds the byte strobed last cycle
                    gtx_d <= din_sel;
                    if (byte_cnt == last_data) begin
                        byte_cnt <= '0;
                        state    <= seq_fcs;
                    end else begin
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                end
                seq_fcs: begin
                    gtx_d <= fcs_byte;
                    if (byte_cnt == frame_len_t'(FCS_LEN - 1)) begin
                        byte_cnt <= '0;
                        state    <= seq_gap;
                    end else begin
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                end
                seq_gap: begin
                    gtx_d  <= '0;
                    gtx_dv <= 1'b0;
                    if (frame_done) begin
                        byte_cnt <= '0;
                        state    <= seq_idle;
                    end else begin
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                end
                default: begin
                    state  <= seq_idle;
                    gtx_dv <= 1'b0;
                end
            endcase
        end
    end

    // fcs generator
    crc32_8023 u_crc (
        .interface_clk (interface_clk),
        .rstn_mac      (rstn_mac),
        .crc_init      (crc_init),
        .crc_calc      (crc_calc),
        .crc_shift     (crc_shift),
        .crc_byte      (din_sel),
        .fcs_byte      (fcs_byte)
    );

endmodule

//--- verilog/tx_queue_select.sv
`timescale 1ns/1ps

module tx_queue_select (
    input  logic                     interface_clk,
    input  logic                     rstn_mac,
    input  logic                     ptr_fifo_empty,
    input  logic                     tptr_fifo_empty,
    input  gmii_tx_pkg::ptr_word_t   ptr_fifo_din,
    input  gmii_tx_pkg::ptr_word_t   tptr_fifo_din,
    input  logic                     frame_done,
    output logic                     ptr_fifo_rd,
    output logic                     tptr_fifo_rd,
    output logic                     frame_start,
    output gmii_tx_pkg::frame_desc_t frame_desc
);
    import gmii_tx_pkg::*;

    sel_state_t state;
    // queue picked in idle, steers the pointer mux
    logic       sel_tte;
    ptr_word_t  ptr_sel;

    assign ptr_sel = sel_tte ? tptr_fifo_din : ptr_fifo_din;

    ////////////////////////////////////////////////////////////
    // arbitration and pointer fetch
    ////////////////////////////////////////////////////////////

    always_ff @(posedge interface_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            state        <= sel_idle;
            sel_tte      <= 1'b0;
            ptr_fifo_rd  <= 1'b0;
            tptr_fifo_rd <= 1'b0;
            frame_start  <= 1'b0;
            frame_desc   <= '0;
        end else begin
            // strobes and start are single cycle
            ptr_fifo_rd  <= 1'b0;
            tptr_fifo_rd <= 1'b0;
            frame_start  <= 1'b0;
            case (state)
                sel_idle: begin
                    // tte queue has strict priority
                    if (!tptr_fifo_empty || !ptr_fifo_empty) begin
                        state        <= sel_ptr_read;
                        sel_tte      <= !tptr_fifo_empty;
                        tptr_fifo_rd <= !tptr_fifo_empty;
                        ptr_fifo_rd  <= tptr_fifo_empty;
                    end
                end
                sel_ptr_read: begin
                    // strobe is out, word lands next cycle
                    state <= sel_ptr_capture;
                end
                sel_ptr_capture: begin
                    frame_desc.tte <= sel_tte;
                    frame_desc.len <= ptr_sel[$bits(frame_len_t)-1:0];
                    frame_start    <= 1'b1;
                    state          <= sel_busy;
                end
                sel_busy: begin
                    // hold off until the gap has run out
                    if (frame_done) begin
                        state <= sel_idle;
                    end
                end
                default: begin
                    state <= sel_idle;
                end
            endcase
        end
    end

endmodule

//--- verilog/crc32_8023.sv
`timescale 1ns/1ps

module crc32_8023 (
    input  logic               interface_clk,
    input  logic               rstn_mac,
    input  logic               crc_init,
    input  logic               crc_calc,
    input  logic               crc_shift,
    input  gmii_tx_pkg::byte_t crc_byte,
    output gmii_tx_pkg::byte_t fcs_byte
);
    import gmii_tx_pkg::*;

    crc_t crc_reg;

    // one byte of reflected crc, bit 0 enters first
    function automatic crc_t crc_next(input crc_t crc, input byte_t d);
        crc_t c;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ d[i]) begin
                c = (c >> 1) ^ CRC_POLY_REFL;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    ////////////////////////////////////////////////////////////
    // crc register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge interface_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            crc_reg <= CRC_INIT;
        end else if (crc_init) begin
            crc_reg <= CRC_INIT;
        end else if (crc_calc) begin
            crc_reg <= crc_next(crc_reg, crc_byte);
        end else if (crc_shift) begin
            // next fcs byte moves into the low lane
            crc_reg <= {8'h00, crc_reg[31:8]};
        end
    end

    // fcs is the complement, low byte first on the wire
    assign fcs_byte = ~crc_reg[7:0];

endmodule

//--- verilog/gmii_tx_pkg.sv
package gmii_tx_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////

    // one gmii or fifo data byte
    typedef logic [7:0]  byte_t;
    // payload length, low 12 bits of a pointer word
    typedef logic [11:0] frame_len_t;
    typedef logic [15:0] ptr_word_t;
    typedef logic [31:0] crc_t;

    ////////////////////////////////////////////////////////////
    // framing constants
    ////////////////////////////////////////////////////////////

    localparam byte_t PREAMBLE_BYTE = 8'h55;
    localparam byte_t SFD_BYTE      = 8'hd5;
    localparam int    PREAMBLE_LEN  = 7;
    localparam int    FCS_LEN       = 4;
    // minimum idle cycles between frames
    localparam int    IFG_LEN       = 12;
    // 802.3 polynomial, bit reversed
    localparam crc_t  CRC_POLY_REFL = 32'hedb8_8320;
    localparam crc_t  CRC_INIT      = 32'hffff_ffff;

    ////////////////////////////////////////////////////////////
    // descriptors and state machines
    ////////////////////////////////////////////////////////////

    // frame handed from arbiter to sequencer
    typedef struct packed {
        logic       tte;
        frame_len_t len;
    } frame_desc_t;

    // flags[3] marks a tte frame, lower flags unused
    typedef struct packed {
        logic [3:0] flags;
        frame_len_t len;
    } mgnt_report_t;

    typedef enum logic [1:0] {
        sel_idle,
        sel_ptr_read,
        sel_ptr_capture,
        sel_busy
    } sel_state_t;

    typedef enum logic [2:0] {
        seq_idle,
        seq_preamble,
        seq_sfd,
        seq_data,
        seq_fcs,
        seq_gap
    } seq_state_t;

endpackage
